/* src/axi_arbiter.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mem_settings.svh"

module axi_arbiter
	import axi_pkg::*;
	import mem_pkg::*;
(
	input  logic               clk,
	input  logic               rst,

	// instruction fetch client, read only
	input  logic               fetch_req,
	input  logic [`ADDR_W-1:0] fetch_addr,
	output logic               fetch_done,
	output logic [`DATA_W-1:0] fetch_rdata,
	output logic               fetch_err,

	// load/store client
	input  logic               lsu_req,
	input  mem_op_e            lsu_op,
	input  logic [`ADDR_W-1:0] lsu_addr,
	input  logic [`DATA_W-1:0] lsu_wdata,
	input  logic [STRB_W-1:0]  lsu_wstrb,
	output logic               lsu_done,
	output logic [`DATA_W-1:0] lsu_rdata,
	output logic               lsu_err,

	axi_lite_if.master         bus
);

	arb_state_e state;
	arb_state_e state_nxt;

	// winner of the current transaction, high for load/store
	logic lsu_sel;

	// response beat captured for the client
	logic [`DATA_W-1:0] rsp_data;
	logic               rsp_err;

	// handshakes
	logic ar_fire;
	logic r_fire;
	logic w_fire;
	logic b_fire;

	// a client still holds req during its done cycle
	// so new requests are only taken once done is gone
	logic take_req;

	assign ar_fire = bus.arvalid && bus.arready;
	assign r_fire  = bus.rvalid && bus.rready;
	assign w_fire  = bus.awvalid && bus.awready && bus.wvalid && bus.wready;
	assign b_fire  = bus.bvalid && bus.bready;

	assign take_req = !fetch_done && !lsu_done;

	// next state
	always_comb begin
		state_nxt = state;
		unique case (state)
			idle: begin
				// load/store wins ties
				if (take_req && lsu_req) begin
					state_nxt = (lsu_op == op_store) ? wr_req : rd_addr;
				end else if (take_req && fetch_req) begin
					state_nxt = rd_addr;
				end
			end
			rd_addr: if (ar_fire) state_nxt = rd_data;
			rd_data: if (r_fire) state_nxt = idle;
			wr_req:  if (w_fire) state_nxt = wr_resp;
			wr_resp: if (b_fire) state_nxt = idle;
			default: state_nxt = idle;
		endcase
	end

	// state and winner
	always_ff @(posedge clk) begin
		if (rst) begin
			state   <= idle;
			lsu_sel <= 1'b0;
		end else begin
			state <= state_nxt;
			// latch the winner only when leaving idle
			if (state == idle && take_req) begin
				lsu_sel <= lsu_req;
			end
		end
	end

	// done pulses, one cycle after the response beat
	always_ff @(posedge clk) begin
		if (rst) begin
			fetch_done <= 1'b0;
			lsu_done   <= 1'b0;
		end else begin
			fetch_done <= (r_fire || b_fire) && !lsu_sel;
			lsu_done   <= (r_fire || b_fire) && lsu_sel;
		end
	end

	// capture response payload
	// store returns zero data
	always_ff @(posedge clk) begin
		if (r_fire) begin
			rsp_data <= bus.rdata;
			rsp_err  <= bus.rresp != okay;
		end else if (b_fire) begin
			rsp_data <= '0;
			rsp_err  <= bus.bresp != okay;
		end
	end

	// read channel, address from the winner
	assign bus.arvalid = state == rd_addr;
	assign bus.araddr  = lsu_sel ? lsu_addr : fetch_addr;
	assign bus.rready  = state == rd_data;

	// write channel, only load/store writes
	assign bus.awvalid = state == wr_req;
	assign bus.wvalid  = state == wr_req;
	assign bus.awaddr  = lsu_addr;
	assign bus.wdata   = lsu_wdata;
	assign bus.wstrb   = lsu_wstrb;
	assign bus.bready  = state == wr_resp;

	// client results, data shared, err only with its own done
	assign fetch_rdata = rsp_data;
	assign lsu_rdata   = rsp_data;
	assign fetch_err   = rsp_err && fetch_done;
	assign lsu_err     = rsp_err && lsu_done;

endmodule

`default_nettype wire

/* src/axi_lite_if.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mem_settings.svh"

interface axi_lite_if
	import axi_pkg::*;
();

	// read address channel
	logic               arvalid;
	logic [`ADDR_W-1:0] araddr;
	logic               arready;

	// read data channel
	logic               rvalid;
	logic [`DATA_W-1:0] rdata;
	axi_resp_e          rresp;
	logic               rready;

	// write address channel
	logic               awvalid;
	logic [`ADDR_W-1:0] awaddr;
	logic               awready;

	// write data channel
	logic               wvalid;
	logic [`DATA_W-1:0] wdata;
	logic [STRB_W-1:0]  wstrb;
	logic               wready;

	// write response channel
	logic               bvalid;
	axi_resp_e          bresp;
	logic               bready;

	// arbiter side
	modport master (
		output arvalid, araddr, input arready,
		input rvalid, rdata, rresp, output rready,
		output awvalid, awaddr, input awready,
		output wvalid, wdata, wstrb, input wready,
		input bvalid, bresp, output bready
	);

	// sram side
	modport slave (
		input arvalid, araddr, output arready,
		output rvalid, rdata, rresp, input rready,
		input awvalid, awaddr, output awready,
		input wvalid, wdata, wstrb, output wready,
		output bvalid, bresp, input bready
	);

endinterface

`default_nettype wire

/* src/axi_pkg.sv */
`default_nettype none

`include "mem_settings.svh"

package axi_pkg;

	// one strobe bit per data byte
	localparam int STRB_W = `DATA_W / 8;

	// response codes on rresp and bresp
	// exokay and decerr never used by this slave
	typedef enum logic [1:0] {
		okay   = 2'd0,
		slverr = 2'd2
	} axi_resp_e;

endpackage

`default_nettype wire

/* src/axi_sram.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mem_settings.svh"

module axi_sram
	import axi_pkg::*;
(
	input logic       clk,
	input logic       rst,
	axi_lite_if.slave bus
);

	// byte offset bits inside one word, ignored on decode
	localparam int OFS_W  = $clog2(`DATA_W / 8);
	// word address width after dropping the offset
	localparam int WORD_W = `ADDR_W - OFS_W;
	// index bits actually used by the array
	localparam int IDX_W  = $clog2(`MEM_WORDS);

	// storage
	logic [`DATA_W-1:0] mem [`MEM_WORDS];

	// word addresses
	logic [WORD_W-1:0] rd_word;
	logic [WORD_W-1:0] wr_word;
	logic [IDX_W-1:0]  rd_idx;
	logic [IDX_W-1:0]  wr_idx;

	// range check results
	logic rd_in;
	logic wr_in;

	// channel handshakes
	logic rd_fire;
	logic wr_fire;

	assign rd_word = bus.araddr[`ADDR_W-1:OFS_W];
	assign wr_word = bus.awaddr[`ADDR_W-1:OFS_W];
	assign rd_idx  = rd_word[IDX_W-1:0];
	assign wr_idx  = wr_word[IDX_W-1:0];

	// anything past the last word is an error
	assign rd_in = rd_word < WORD_W'(`MEM_WORDS);
	assign wr_in = wr_word < WORD_W'(`MEM_WORDS);

	// no queue, so accept only when the response slot frees up
	assign bus.arready = !bus.rvalid || bus.rready;
	assign bus.awready = !bus.bvalid || bus.bready;
	assign bus.wready  = !bus.bvalid || bus.bready;

	assign rd_fire = bus.arvalid && bus.arready;
	// address and data must arrive together
	assign wr_fire = bus.awvalid && bus.awready && bus.wvalid && bus.wready;

	// byte merge under strobes
	// out-of-range writes are dropped
	always_ff @(posedge clk) begin
		if (wr_fire && wr_in) begin
			for (int b = 0; b < STRB_W; b++) begin
				if (bus.wstrb[b]) begin
					mem[wr_idx][8*b +: 8] <= bus.wdata[8*b +: 8];
				end
			end
		end
	end

	// write response valid
	always_ff @(posedge clk) begin
		if (rst) begin
			bus.bvalid <= 1'b0;
		end else if (wr_fire) begin
			bus.bvalid <= 1'b1;
		end else if (bus.bready) begin
			bus.bvalid <= 1'b0;
		end
	end

	// write response code, held while bvalid waits
	always_ff @(posedge clk) begin
		if (wr_fire) begin
			bus.bresp <= wr_in ? okay : slverr;
		end
	end

	// read valid
	always_ff @(posedge clk) begin
		if (rst) begin
			bus.rvalid <= 1'b0;
		end else if (rd_fire) begin
			bus.rvalid <= 1'b1;
		end else if (bus.rready) begin
			bus.rvalid <= 1'b0;
		end
	end

	// registered read data and code
	// zero comes back for a bad address
	always_ff @(posedge clk) begin
		if (rd_fire) begin
			bus.rdata <= rd_in ? mem[rd_idx] : '0;
			bus.rresp <= rd_in ? okay : slverr;
		end
	end

endmodule

`default_nettype wire

/* src/mem_pkg.sv */
`default_nettype none

package mem_pkg;

	// load/store client operation
	typedef enum logic {
		op_load  = 1'b0,
		op_store = 1'b1
	} mem_op_e;

	// arbiter / bus master states
	// idle waits for a client request
	// rd_addr and wr_req hold the address phase
	// rd_data and wr_resp wait for the response beat
	typedef enum logic [2:0] {
		idle    = 3'd0,
		rd_addr = 3'd1,
		rd_data = 3'd2,
		wr_req  = 3'd3,
		wr_resp = 3'd4
	} arb_state_e;

endpackage

`default_nettype wire

/* src/mem_settings.svh */
`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

// byte address width on the bus
`define ADDR_W 32

// data width, one 64-bit word per beat
`define DATA_W 64

// sram depth in 64-bit words
// must be a power of two for the index slice
`define MEM_WORDS 256

`endif

/* src/mem_subsys_top.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mem_settings.svh"

module mem_subsys_top
	import axi_pkg::*;
	import mem_pkg::*;
(
	input  logic               clk,
	input  logic               rst,

	// fetch client
	input  logic               fetch_req,
	input  logic [`ADDR_W-1:0] fetch_addr,
	output logic               fetch_done,
	output logic [`DATA_W-1:0] fetch_rdata,
	output logic               fetch_err,

	// load/store client
	input  logic               lsu_req,
	input  mem_op_e            lsu_op,
	input  logic [`ADDR_W-1:0] lsu_addr,
	input  logic [`DATA_W-1:0] lsu_wdata,
	input  logic [STRB_W-1:0]  lsu_wstrb,
	output logic               lsu_done,
	output logic [`DATA_W-1:0] lsu_rdata,
	output logic               lsu_err
);

	// single shared axi-lite bus
	axi_lite_if bus_if ();

	// two clients onto one master port
	axi_arbiter i_axi_arbiter (
		.clk         (clk),
		.rst         (rst),
		.fetch_req   (fetch_req),
		.fetch_addr  (fetch_addr),
		.fetch_done  (fetch_done),
		.fetch_rdata (fetch_rdata),
		.fetch_err   (fetch_err),
		.lsu_req     (lsu_req),
		.lsu_op      (lsu_op),
		.lsu_addr    (lsu_addr),
		.lsu_wdata   (lsu_wdata),
		.lsu_wstrb   (lsu_wstrb),
		.lsu_done    (lsu_done),
		.lsu_rdata   (lsu_rdata),
		.lsu_err     (lsu_err),
		.bus         (bus_if.master)
	);

	// word array slave
	axi_sram i_axi_sram (
		.clk (clk),
		.rst (rst),
		.bus (bus_if.slave)
	);

endmodule

`default_nettype wire

/* testbench/mem_subsys_chk.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mem_settings.svh"

module mem_subsys_chk
	import axi_pkg::*;
	import mem_pkg::*;
(
	input logic               clk,
	input logic               rst,
	input logic               arvalid,
	input logic               rvalid,
	input logic               rready,
	input logic [`DATA_W-1:0] rdata,
	input axi_resp_e          rresp,
	input logic               bvalid,
	input logic               bready,
	input axi_resp_e          bresp,
	input logic               fetch_done,
	input logic               lsu_done,
	input arb_state_e         state
);

	// number of failed properties
	int fail_count = 0;

	// read beat holds until taken
	rvalid_hold: assert property (@(posedge clk) disable iff (rst)
		rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
		else begin
			$error("rvalid or its payload changed before rready");
			fail_count++;
		end

	// write response holds until taken
	bvalid_hold: assert property (@(posedge clk) disable iff (rst)
		bvalid && !bready |=> bvalid && $stable(bresp))
		else begin
			$error("bvalid or bresp changed before bready");
			fail_count++;
		end

	// response valids cleared by reset
	valid_after_rst: assert property (@(posedge clk)
		rst |=> !rvalid && !bvalid)
		else begin
			$error("rvalid or bvalid high after reset");
			fail_count++;
		end

	// done pulses last one cycle
	fetch_done_pulse: assert property (@(posedge clk) disable iff (rst)
		fetch_done |=> !fetch_done)
		else begin
			$error("fetch_done longer than one cycle");
			fail_count++;
		end

	lsu_done_pulse: assert property (@(posedge clk) disable iff (rst)
		lsu_done |=> !lsu_done)
		else begin
			$error("lsu_done longer than one cycle");
			fail_count++;
		end

	// no read address during a write transaction
	no_read_in_write: assert property (@(posedge clk) disable iff (rst)
		(state inside {wr_req, wr_resp}) || bvalid |-> !arvalid)
		else begin
			$error("arvalid raised while a write was in progress");
			fail_count++;
		end

endmodule

// bus signals through the shared interface and state from the arbiter
bind mem_subsys_top mem_subsys_chk i_mem_subsys_chk (
	.clk        (clk),
	.rst        (rst),
	.arvalid    (bus_if.arvalid),
	.rvalid     (bus_if.rvalid),
	.rready     (bus_if.rready),
	.rdata      (bus_if.rdata),
	.rresp      (bus_if.rresp),
	.bvalid     (bus_if.bvalid),
	.bready     (bus_if.bready),
	.bresp      (bus_if.bresp),
	.fetch_done (fetch_done),
	.lsu_done   (lsu_done),
	.state      (i_axi_arbiter.state)
);

`default_nettype wire

/* testbench/mem_subsys_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mem_settings.svh"

module mem_subsys_tb
	import axi_pkg::*;
	import mem_pkg::*;
();

	// negedges to wait for a done pulse
	localparam int TIMEOUT = 50;

	// one table row with fetch and lsu enables
	typedef struct packed {
		logic               fetch_en;
		logic [`ADDR_W-1:0] fetch_addr;
		logic               lsu_en;
		mem_op_e            lsu_op;
		logic [`ADDR_W-1:0] lsu_addr;
		logic [`DATA_W-1:0] wdata;
		logic [STRB_W-1:0]  wstrb;
		logic               rand_data;
	} step_t;

	logic               clk;
	logic               rst;
	logic               fetch_req;
	logic [`ADDR_W-1:0] fetch_addr;
	logic               fetch_done;
	logic [`DATA_W-1:0] fetch_rdata;
	logic               fetch_err;
	logic               lsu_req;
	mem_op_e            lsu_op;
	logic [`ADDR_W-1:0] lsu_addr;
	logic [`DATA_W-1:0] lsu_wdata;
	logic [STRB_W-1:0]  lsu_wstrb;
	logic               lsu_done;
	logic [`DATA_W-1:0] lsu_rdata;
	logic               lsu_err;

	// reference memory for expected read data
	logic [`DATA_W-1:0] ref_mem [`MEM_WORDS];
	step_t              steps [$];
	logic [15:0]        lfsr_state;
	int                 checks;
	int                 errors;
	int                 timeouts;
	int                 chk_fails;

	mem_subsys_top i_mem_subsys_top (
		.clk         (clk),
		.rst         (rst),
		.fetch_req   (fetch_req),
		.fetch_addr  (fetch_addr),
		.fetch_done  (fetch_done),
		.fetch_rdata (fetch_rdata),
		.fetch_err   (fetch_err),
		.lsu_req     (lsu_req),
		.lsu_op      (lsu_op),
		.lsu_addr    (lsu_addr),
		.lsu_wdata   (lsu_wdata),
		.lsu_wstrb   (lsu_wstrb),
		.lsu_done    (lsu_done),
		.lsu_rdata   (lsu_rdata),
		.lsu_err     (lsu_err)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// 16-bit fibonacci lfsr with taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	// one lfsr step per data bit
	task automatic random_word(output logic [`DATA_W-1:0] w);
		for (int i = 0; i < `DATA_W; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			w = {w[`DATA_W-2:0], lfsr_state[0]};
		end
	endtask

	// word index is the byte address over eight
	function automatic logic in_range(input logic [`ADDR_W-1:0] a);
		return (a >> 3) < `MEM_WORDS;
	endfunction

	function automatic logic [`DATA_W-1:0] expected_read(input logic [`ADDR_W-1:0] a);
		return in_range(a) ? ref_mem[a >> 3] : '0;
	endfunction

	// bytes with strobe set take the new data
	task automatic apply_store(input logic [`ADDR_W-1:0] a, input logic [`DATA_W-1:0] d,
		input logic [STRB_W-1:0] s);
		if (in_range(a)) begin
			for (int b = 0; b < STRB_W; b++) begin
				if (s[b]) ref_mem[a >> 3][8*b +: 8] = d[8*b +: 8];
			end
		end
	endtask

	task automatic check_value(input string name, input logic [`DATA_W-1:0] exp,
		input logic [`DATA_W-1:0] got);
		checks++;
		assert (got === exp) else begin
			$display("Fail at %0t: %s expected %h, got %h", $time, name, exp, got);
			errors++;
		end
	endtask

	// done and results sampled on the falling edge
	task automatic wait_done(input logic lsu_side, output logic seen);
		int n;
		seen = 1'b0;
		n = 0;
		while (!seen && n < TIMEOUT) begin
			@(negedge clk);
			n++;
			assert (!(lsu_side ? fetch_done : lsu_done)) else begin
				$display("done from the wrong client at %0t", $time);
				errors++;
			end
			seen = lsu_side ? lsu_done : fetch_done;
		end
		if (!seen) begin
			$display("timeout waiting for %s at %0t", lsu_side ? "lsu_done" : "fetch_done",
				$time);
			timeouts++;
		end
	endtask

	task automatic add_step(input logic fe, input logic [`ADDR_W-1:0] fa, input logic le,
		input mem_op_e op, input logic [`ADDR_W-1:0] la, input logic [`DATA_W-1:0] d,
		input logic [STRB_W-1:0] s, input logic rnd);
		step_t t;
		t.fetch_en = fe;
		t.fetch_addr = fa;
		t.lsu_en = le;
		t.lsu_op = op;
		t.lsu_addr = la;
		t.wdata = d;
		t.wstrb = s;
		t.rand_data = rnd;
		steps.push_back(t);
	endtask

	task automatic run_step(input step_t t);
		logic [`DATA_W-1:0] wdata;
		logic [`DATA_W-1:0] lsu_exp;
		logic [`DATA_W-1:0] fetch_exp;
		logic               seen;
		wdata = t.wdata;
		lsu_exp = '0;
		fetch_exp = '0;
		if (t.rand_data) random_word(wdata);
		// lsu wins the bus first and its store is seen by the fetch
		if (t.lsu_en && t.lsu_op == op_store) apply_store(t.lsu_addr, wdata, t.wstrb);
		if (t.lsu_en && t.lsu_op == op_load) lsu_exp = expected_read(t.lsu_addr);
		if (t.fetch_en) fetch_exp = expected_read(t.fetch_addr);
		@(posedge clk);
		lsu_req    <= t.lsu_en;
		lsu_op     <= t.lsu_op;
		lsu_addr   <= t.lsu_addr;
		lsu_wdata  <= wdata;
		lsu_wstrb  <= t.wstrb;
		fetch_req  <= t.fetch_en;
		fetch_addr <= t.fetch_addr;
		if (t.lsu_en) begin
			wait_done(1'b1, seen);
			if (seen) begin
				if (t.lsu_op == op_load) check_value("lsu_rdata", lsu_exp, lsu_rdata);
				check_value("lsu_err", !in_range(t.lsu_addr), lsu_err);
			end
			@(posedge clk);
			lsu_req <= 1'b0;
		end
		if (t.fetch_en) begin
			wait_done(1'b0, seen);
			if (seen) begin
				check_value("fetch_rdata", fetch_exp, fetch_rdata);
				check_value("fetch_err", !in_range(t.fetch_addr), fetch_err);
			end
			@(posedge clk);
			fetch_req <= 1'b0;
		end
	endtask

	initial begin
		rst        = 1'b1;
		fetch_req  = 1'b0;
		fetch_addr = '0;
		lsu_req    = 1'b0;
		lsu_op     = op_load;
		lsu_addr   = '0;
		lsu_wdata  = '0;
		lsu_wstrb  = '0;
		lfsr_state = 16'd13585;
		checks     = 0;
		errors     = 0;
		timeouts   = 0;
		chk_fails  = 0;

		// full store then load
		add_step(0, 'h0, 1, op_store, 'h000, 64'h1122334455667788, 'hff, 0);
		add_step(0, 'h0, 1, op_load, 'h000, '0, '0, 0);
		// partial strobes over an older word
		add_step(0, 'h0, 1, op_store, 'h008, 64'ha5a5a5a5a5a5a5a5, 'hff, 0);
		add_step(0, 'h0, 1, op_store, 'h008, 64'h0102030405060708, 'h0f, 0);
		add_step(0, 'h0, 1, op_load, 'h008, '0, '0, 0);
		add_step(0, 'h0, 1, op_store, 'h00e, 64'h99aabbccddeeff00, 'hc0, 0);
		add_step(0, 'h0, 1, op_load, 'h008, '0, '0, 0);
		// fetch with low bits set
		add_step(0, 'h0, 1, op_store, 'h010, 64'hdeadbeefcafef00d, 'hff, 0);
		add_step(1, 'h015, 0, op_load, 'h0, '0, '0, 0);
		// both clients at once
		add_step(1, 'h01a, 1, op_store, 'h018, 64'h0f0e0d0c0b0a0908, 'hff, 0);
		add_step(1, 'h01f, 1, op_load, 'h000, '0, '0, 0);
		// last word in range
		add_step(0, 'h0, 1, op_store, 'h7f8, 64'h7766554433221100, 'hff, 0);
		add_step(1, 'h7f8, 0, op_load, 'h0, '0, '0, 0);
		// out of range where word 256 would alias word 0
		add_step(0, 'h0, 1, op_store, 'h800, 64'hffffffffffffffff, 'hff, 0);
		add_step(0, 'h0, 1, op_load, 'h800, '0, '0, 0);
		add_step(1, 'h10000, 0, op_load, 'h0, '0, '0, 0);
		add_step(0, 'h0, 1, op_load, 'h000, '0, '0, 0);
		// random data stores each followed by a load
		add_step(0, 'h0, 1, op_store, 'h100, '0, 'hff, 1);
		add_step(0, 'h0, 1, op_load, 'h100, '0, '0, 0);
		add_step(0, 'h0, 1, op_store, 'h108, '0, 'hff, 1);
		add_step(0, 'h0, 1, op_load, 'h108, '0, '0, 0);
		add_step(0, 'h0, 1, op_store, 'h100, '0, 'h3c, 1);
		add_step(0, 'h0, 1, op_load, 'h100, '0, '0, 0);

		repeat (3) @(posedge clk);
		rst <= 1'b0;

		foreach (steps[i]) begin
			run_step(steps[i]);
		end
		repeat (2) @(posedge clk);

		chk_fails = i_mem_subsys_top.i_mem_subsys_chk.fail_count;
		$display("checks %0d, errors %0d, timeouts %0d, assertion failures %0d",
			checks, errors, timeouts, chk_fails);
		if (errors == 0 && timeouts == 0 && chk_fails == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+src
src/axi_pkg.sv
src/mem_pkg.sv
src/axi_lite_if.sv
src/axi_sram.sv
src/axi_arbiter.sv
src/mem_subsys_top.sv
testbench/mem_subsys_chk.sv
testbench/mem_subsys_tb.sv
